// File: verilog/cps_video_pkg.sv
package cps_video_pkg;

    // length of the CPS-B configuration chain in bytes
    localparam int CFG_BYTES = 21;

    // CPS-A word indices
    localparam logic [4:0] A_VRAM_OBJ_BASE  = 5'h00;
    localparam logic [4:0] A_VRAM1_BASE     = 5'h01;
    localparam logic [4:0] A_VRAM2_BASE     = 5'h02;
    localparam logic [4:0] A_VRAM3_BASE     = 5'h03;
    localparam logic [4:0] A_VRAM_ROW_BASE  = 5'h04;
    localparam logic [4:0] A_PAL_BASE       = 5'h05;
    localparam logic [4:0] A_HPOS1          = 5'h06;
    localparam logic [4:0] A_VPOS1          = 5'h07;
    localparam logic [4:0] A_HPOS2          = 5'h08;
    localparam logic [4:0] A_VPOS2          = 5'h09;
    localparam logic [4:0] A_HPOS3          = 5'h0a;
    localparam logic [4:0] A_VPOS3          = 5'h0b;
    localparam logic [4:0] A_HSTAR1         = 5'h0c;
    localparam logic [4:0] A_VSTAR1         = 5'h0d;
    localparam logic [4:0] A_HSTAR2         = 5'h0e;
    localparam logic [4:0] A_VSTAR2         = 5'h0f;
    localparam logic [4:0] A_VRAM_STAR_BASE = 5'h10;
    localparam logic [4:0] A_PPU_CTRL       = 5'h11;

    typedef struct packed {
        logic [4:0]  addr;
        logic [1:0]  dsn;   // byte selects, active low
        logic [15:0] data;
    } cpu_bus_t;

    typedef struct packed {
        logic [15:0] vram_obj_base;
        logic [15:0] vram1_base;
        logic [15:0] vram2_base;
        logic [15:0] vram3_base;
        logic [15:0] vram_row_base;
        logic [15:0] pal_base;
        logic [15:0] hpos1;
        logic [15:0] vpos1;
        logic [15:0] hpos2;
        logic [15:0] vpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos3;
        logic [15:0] hstar1;
        logic [15:0] vstar1;
        logic [15:0] hstar2;
        logic [15:0] vstar2;
        logic [15:0] vram_star_base;
        logic [15:0] ppu_ctrl;
    } cpsa_regs_t;

    typedef struct packed {
        logic [4:0]      id;
        logic [4:0]      mult1;
        logic [4:0]      mult2;
        logic [4:0]      rslt0;
        logic [4:0]      rslt1;
        logic [4:0]      layer;
        logic [4:0]      prio0;
        logic [4:0]      prio1;
        logic [4:0]      prio2;
        logic [4:0]      prio3;
        logic [4:0]      pal_page;
        logic [7:0]      cpsb_id;
        logic [3:0][7:0] layer_mask;
        logic [5:0]      game;
        logic [15:0]     bank_offset;
        logic [15:0]     bank_mask;
    } cpsb_map_t;

    typedef struct packed {
        logic [15:0]      layer_ctrl;
        logic [3:0][15:0] prio;   // indexed by priority group
    } layer_cfg_t;

    typedef struct packed {
        logic [3:0] color;   // 4'hf is transparent
        logic [1:0] group;
        logic [4:0] pal;
    } pixel_t;

    localparam pixel_t PXL_CLEAR = '{color: 4'hf, group: 2'd0, pal: 5'd0};

endpackage

// File: verilog/cpsa_regs.sv
`timescale 1ns/1ns

module cpsa_regs (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  logic                     ppu1_cs,
    input  cps_video_pkg::cpu_bus_t  bus,
    output cps_video_pkg::cpsa_regs_t regs,
    output logic                     pal_copy
);

    // set by a palette base write, cleared when the pulse goes out
    logic pre_copy;

    // only lanes with a low byte select take the new data
    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_word,
        input logic [15:0] new_word,
        input logic [1:0]  dsn
    );
        logic [15:0] merged;
        merged[15:8] = dsn[1] ? old_word[15:8] : new_word[15:8];
        merged[7:0]  = dsn[0] ? old_word[7:0]  : new_word[7:0];
        return merged;
    endfunction

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            regs <= '0;
        end else if (ppu1_cs) begin
            case (bus.addr)
                cps_video_pkg::A_VRAM_OBJ_BASE:
                    regs.vram_obj_base <= lane_merge(regs.vram_obj_base, bus.data, bus.dsn);
                cps_video_pkg::A_VRAM1_BASE:
                    regs.vram1_base <= lane_merge(regs.vram1_base, bus.data, bus.dsn);
                cps_video_pkg::A_VRAM2_BASE:
                    regs.vram2_base <= lane_merge(regs.vram2_base, bus.data, bus.dsn);
                cps_video_pkg::A_VRAM3_BASE:
                    regs.vram3_base <= lane_merge(regs.vram3_base, bus.data, bus.dsn);
                cps_video_pkg::A_VRAM_ROW_BASE:
                    regs.vram_row_base <= lane_merge(regs.vram_row_base, bus.data, bus.dsn);
                cps_video_pkg::A_PAL_BASE:
                    regs.pal_base <= lane_merge(regs.pal_base, bus.data, bus.dsn);
                cps_video_pkg::A_HPOS1:
                    regs.hpos1 <= lane_merge(regs.hpos1, bus.data, bus.dsn);
                cps_video_pkg::A_VPOS1:
                    regs.vpos1 <= lane_merge(regs.vpos1, bus.data, bus.dsn);
                cps_video_pkg::A_HPOS2:
                    regs.hpos2 <= lane_merge(regs.hpos2, bus.data, bus.dsn);
                cps_video_pkg::A_VPOS2:
                    regs.vpos2 <= lane_merge(regs.vpos2, bus.data, bus.dsn);
                cps_video_pkg::A_HPOS3:
                    regs.hpos3 <= lane_merge(regs.hpos3, bus.data, bus.dsn);
                cps_video_pkg::A_VPOS3:
                    regs.vpos3 <= lane_merge(regs.vpos3, bus.data, bus.dsn);
                cps_video_pkg::A_HSTAR1:
                    regs.hstar1 <= lane_merge(regs.hstar1, bus.data, bus.dsn);
                cps_video_pkg::A_VSTAR1:
                    regs.vstar1 <= lane_merge(regs.vstar1, bus.data, bus.dsn);
                cps_video_pkg::A_HSTAR2:
                    regs.hstar2 <= lane_merge(regs.hstar2, bus.data, bus.dsn);
                cps_video_pkg::A_VSTAR2:
                    regs.vstar2 <= lane_merge(regs.vstar2, bus.data, bus.dsn);
                cps_video_pkg::A_VRAM_STAR_BASE:
                    regs.vram_star_base <= lane_merge(regs.vram_star_base, bus.data, bus.dsn);
                cps_video_pkg::A_PPU_CTRL:
                    regs.ppu_ctrl <= lane_merge(regs.ppu_ctrl, bus.data, bus.dsn);
                default: begin
                    // indices 18 to 31 are not mapped
                end
            endcase
        end
    end

    // the copy request waits until the chip select drops,
    // by then the palette base has settled
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            pre_copy <= 1'b0;
            pal_copy <= 1'b0;
        end else begin
            if (!ppu1_cs && pre_copy) begin
                pal_copy <= 1'b1;
                pre_copy <= 1'b0;
            end else begin
                pal_copy <= 1'b0;
            end
            if (ppu1_cs && bus.addr == cps_video_pkg::A_PAL_BASE) begin
                pre_copy <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/cpsb_cfg.sv
`timescale 1ns/1ns

module cpsb_cfg (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      cfg_we,
    input  logic [7:0]                cfg_data,
    output cps_video_pkg::cpsb_map_t  map
);

    // byte 0 is the most recent byte shifted in
    logic [cps_video_pkg::CFG_BYTES-1:0][7:0] chain;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            chain <= '0;
        end else if (cfg_we) begin
            chain <= {chain[cps_video_pkg::CFG_BYTES-2:0], cfg_data};
        end
    end

    // address bytes hold byte offsets, the bus works in words
    always_comb begin
        map.id       = chain[0][5:1];
        map.cpsb_id  = chain[1];
        map.mult1    = chain[2][5:1];
        map.mult2    = chain[3][5:1];
        map.rslt0    = chain[4][5:1];
        map.rslt1    = chain[5][5:1];
        map.layer    = chain[6][5:1];
        map.prio0    = chain[7][5:1];
        map.prio1    = chain[8][5:1];
        map.prio2    = chain[9][5:1];
        map.prio3    = chain[10][5:1];
        map.pal_page = chain[11][5:1];
    end

    // layer masks, a fourth scroll layer would reuse mask 3
    always_comb begin
        map.layer_mask[0] = chain[12];
        map.layer_mask[1] = chain[13];
        map.layer_mask[2] = chain[14];
        map.layer_mask[3] = chain[15];
    end

    // ROM banking fields
    always_comb begin
        map.game        = chain[16][5:0];
        map.bank_offset = {chain[18], chain[17]};
        map.bank_mask   = {chain[20], chain[19]};
    end

endmodule

// File: verilog/cpsb_regs.sv
`timescale 1ns/1ns

module cpsb_regs (
    input  logic                       clk,
    input  logic                       reg_rst,
    input  logic                       ppu2_cs,
    input  cps_video_pkg::cpu_bus_t    bus,
    input  cps_video_pkg::cpsb_map_t   map,
    output logic [15:0]                mmr_dout,
    output cps_video_pkg::layer_cfg_t  lcfg,
    output logic [5:0]                 pal_page_en
);

    // positions in the hit vector
    localparam int H_ID       = 0;
    localparam int H_MULT1    = 1;
    localparam int H_MULT2    = 2;
    localparam int H_RSLT0    = 3;
    localparam int H_RSLT1    = 4;
    localparam int H_LAYER    = 5;
    localparam int H_PRIO0    = 6;
    localparam int H_PAL_PAGE = 10;

    logic [10:0] hit;
    logic        wr_en;
    logic [15:0] mult1;
    logic [15:0] mult2;
    logic [31:0] product;
    logic [15:0] grp_id;
    logic [15:0] grp_lp;
    logic [15:0] rd_word;

    always_comb begin
        hit[H_ID]       = bus.addr == map.id;
        hit[H_MULT1]    = bus.addr == map.mult1;
        hit[H_MULT2]    = bus.addr == map.mult2;
        hit[H_RSLT0]    = bus.addr == map.rslt0;
        hit[H_RSLT1]    = bus.addr == map.rslt1;
        hit[H_LAYER]    = bus.addr == map.layer;
        hit[H_PRIO0]    = bus.addr == map.prio0;
        hit[H_PRIO0+1]  = bus.addr == map.prio1;
        hit[H_PRIO0+2]  = bus.addr == map.prio2;
        hit[H_PRIO0+3]  = bus.addr == map.prio3;
        hit[H_PAL_PAGE] = bus.addr == map.pal_page;
    end

    // word writes only
    assign wr_en = ppu2_cs && bus.dsn == 2'b00;

    // ID and multiplier group
    always_comb begin
        grp_id = 16'hffff;
        if (hit[H_ID]) begin
            grp_id = {4'h0, map.cpsb_id[7:4], 4'h0, map.cpsb_id[3:0]};
        end else if (hit[H_MULT1]) begin
            grp_id = mult1;
        end else if (hit[H_MULT2]) begin
            grp_id = mult2;
        end else if (hit[H_RSLT0]) begin
            grp_id = product[15:0];
        end else if (hit[H_RSLT1]) begin
            grp_id = product[31:16];
        end
    end

    // layer and priority group
    always_comb begin
        grp_lp = 16'hffff;
        if (hit[H_LAYER]) begin
            grp_lp = lcfg.layer_ctrl;
        end else if (hit[H_PRIO0]) begin
            grp_lp = lcfg.prio[0];
        end else if (hit[H_PRIO0+1]) begin
            grp_lp = lcfg.prio[1];
        end else if (hit[H_PRIO0+2]) begin
            grp_lp = lcfg.prio[2];
        end else if (hit[H_PRIO0+3]) begin
            grp_lp = lcfg.prio[3];
        end else if (hit[H_PAL_PAGE]) begin
            grp_lp = {10'd0, pal_page_en};
        end
    end

    // 5'h1f never answers
    always_comb begin
        if (&bus.addr) begin
            rd_word = 16'hffff;
        end else if (|hit[H_RSLT1:H_ID]) begin
            rd_word = grp_id;
        end else begin
            rd_word = grp_lp;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && hit[H_MULT1]) begin
            mult1 <= bus.data;
        end
        if (wr_en && hit[H_MULT2]) begin
            mult2 <= bus.data;
        end
        product <= mult1 * mult2;
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mmr_dout        <= 16'hffff;
            lcfg.layer_ctrl <= 16'd0;
            lcfg.prio       <= {4{16'hffff}};
            pal_page_en     <= 6'h3f;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_word;
            if (wr_en && hit[H_LAYER]) begin
                lcfg.layer_ctrl <= bus.data;
            end
            for (int i = 0; i < 4; i++) begin
                if (wr_en && hit[H_PRIO0+i]) begin
                    lcfg.prio[i] <= bus.data;
                end
            end
            if (wr_en && hit[H_PAL_PAGE]) begin
                pal_page_en <= bus.data[5:0];
            end
        end
    end

endmodule

// File: verilog/layer_mixer.sv
`timescale 1ns/1ns

module layer_mixer (
    input  logic                       clk,
    input  logic                       reg_rst,
    input  cps_video_pkg::layer_cfg_t  lcfg,
    input  cps_video_pkg::cpsb_map_t   map,
    input  cps_video_pkg::pixel_t      obj_pxl,
    input  cps_video_pkg::pixel_t      scr1_pxl,
    input  cps_video_pkg::pixel_t      scr2_pxl,
    input  cps_video_pkg::pixel_t      scr3_pxl,
    output cps_video_pkg::pixel_t      mix_pxl
);

    // layer 0 is the sprite layer, 1 to 3 the scroll layers
    cps_video_pkg::pixel_t layer_pxl [0:3];
    logic [3:0]            layer_en;
    cps_video_pkg::pixel_t pick;

    assign layer_pxl[0] = obj_pxl;
    assign layer_pxl[1] = scr1_pxl;
    assign layer_pxl[2] = scr2_pxl;
    assign layer_pxl[3] = scr3_pxl;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            layer_en[i] = |(lcfg.layer_ctrl[7:0] & map.layer_mask[i]);
        end
    end

    // walk the draw order from back to front
    always_comb begin : resolve
        logic [1:0]            lay;
        cps_video_pkg::pixel_t cand;
        logic                  pick_prio;
        pick      = cps_video_pkg::PXL_CLEAR;
        pick_prio = 1'b0;
        for (int k = 0; k < 4; k++) begin
            lay  = lcfg.layer_ctrl[6 + 2*k +: 2];
            cand = layer_pxl[lay];
            if (layer_en[lay] && cand.color != 4'hf) begin
                if (lay == 2'd0) begin
                    // sprite loses against a priority scroll pixel below it
                    if (!pick_prio) begin
                        pick = cand;
                    end
                end else begin
                    pick      = cand;
                    pick_prio = lcfg.prio[cand.group][cand.color];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mix_pxl <= cps_video_pkg::PXL_CLEAR;
        end else begin
            mix_pxl <= pick;
        end
    end

endmodule

// File: verilog/cps_video_ctrl.sv
`timescale 1ns/1ns

module cps_video_ctrl (
    input  logic                       clk,
    input  logic                       reg_rst,
    // CPU side
    input  cps_video_pkg::cpu_bus_t    bus,
    input  logic                       ppu1_cs,
    input  logic                       ppu2_cs,
    output logic [15:0]                mmr_dout,
    // configuration chain
    input  logic                       cfg_we,
    input  logic [7:0]                 cfg_data,
    // pixels
    input  cps_video_pkg::pixel_t      obj_pxl,
    input  cps_video_pkg::pixel_t      scr1_pxl,
    input  cps_video_pkg::pixel_t      scr2_pxl,
    input  cps_video_pkg::pixel_t      scr3_pxl,
    output cps_video_pkg::pixel_t      mix_pxl,
    // register outputs
    output cps_video_pkg::cpsa_regs_t  cpsa,
    output logic                       pal_copy,
    output logic [5:0]                 pal_page_en,
    output logic [5:0]                 game,
    output logic [15:0]                bank_offset,
    output logic [15:0]                bank_mask
);

    cps_video_pkg::cpsb_map_t  map;
    cps_video_pkg::layer_cfg_t lcfg;

    assign game        = map.game;
    assign bank_offset = map.bank_offset;
    assign bank_mask   = map.bank_mask;

    cpsa_regs u_cpsa_regs (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu1_cs  (ppu1_cs),
        .bus      (bus),
        .regs     (cpsa),
        .pal_copy (pal_copy)
    );

    cpsb_cfg u_cpsb_cfg (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (map)
    );

    cpsb_regs u_cpsb_regs (
        .clk         (clk),
        .reg_rst     (reg_rst),
        .ppu2_cs     (ppu2_cs),
        .bus         (bus),
        .map         (map),
        .mmr_dout    (mmr_dout),
        .lcfg        (lcfg),
        .pal_page_en (pal_page_en)
    );

    layer_mixer u_layer_mixer (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .lcfg     (lcfg),
        .map      (map),
        .obj_pxl  (obj_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .scr3_pxl (scr3_pxl),
        .mix_pxl  (mix_pxl)
    );

endmodule

// File: tb/cps_video_ctrl_tb.sv
`timescale 1ns/1ns

module cps_video_ctrl_tb;

    // the tests need roughly 2000 cycles in all
    localparam int MAX_CYCLES = 4000;
    localparam int MIX_ROUNDS = 6;
    localparam int MIX_PIXELS = 280;

    // CPS-B word addresses placed by the configuration chain
    localparam logic [4:0] W_ID    = 5'h09;
    localparam logic [4:0] W_MULT1 = 5'h10;
    localparam logic [4:0] W_MULT2 = 5'h11;
    localparam logic [4:0] W_RSLT0 = 5'h0a;
    localparam logic [4:0] W_RSLT1 = 5'h0b;
    localparam logic [4:0] W_LAYER = 5'h13;
    localparam logic [4:0] W_PRIO0 = 5'h14;
    localparam logic [4:0] W_PRIO1 = 5'h15;
    localparam logic [4:0] W_PRIO2 = 5'h16;
    localparam logic [4:0] W_PRIO3 = 5'h17;
    localparam logic [4:0] W_PAGE  = 5'h18;
    localparam logic [7:0] BOARD_ID = 8'h7a;

    logic                      clk;
    logic                      reg_rst;
    cps_video_pkg::cpu_bus_t   bus;
    logic                      ppu1_cs;
    logic                      ppu2_cs;
    logic [15:0]               mmr_dout;
    logic                      cfg_we;
    logic [7:0]                cfg_data;
    cps_video_pkg::pixel_t     obj_pxl;
    cps_video_pkg::pixel_t     scr1_pxl;
    cps_video_pkg::pixel_t     scr2_pxl;
    cps_video_pkg::pixel_t     scr3_pxl;
    cps_video_pkg::pixel_t     mix_pxl;
    cps_video_pkg::cpsa_regs_t cpsa;
    logic                      pal_copy;
    logic [5:0]                pal_page_en;
    logic [5:0]                game;
    logic [15:0]               bank_offset;
    logic [15:0]               bank_mask;

    logic [31:0] lfsr = 32'hc3f1;
    int          cycles = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    // register state as the testbench expects it
    logic [15:0]      a_model [0:17];
    logic [7:0]       cfg_bytes [0:cps_video_pkg::CFG_BYTES-1];
    logic [15:0]      m_mult1;
    logic [15:0]      m_mult2;
    logic [15:0]      m_layer = 16'h0000;
    logic [3:0][15:0] m_prio = {4{16'hffff}};
    logic [5:0]       m_page = 6'h3f;

    // expected mixer outputs, oldest first
    cps_video_pkg::pixel_t mix_queue [$];

    cps_video_ctrl UUT (
        .clk         (clk),
        .reg_rst     (reg_rst),
        .bus         (bus),
        .ppu1_cs     (ppu1_cs),
        .ppu2_cs     (ppu2_cs),
        .mmr_dout    (mmr_dout),
        .cfg_we      (cfg_we),
        .cfg_data    (cfg_data),
        .obj_pxl     (obj_pxl),
        .scr1_pxl    (scr1_pxl),
        .scr2_pxl    (scr2_pxl),
        .scr3_pxl    (scr3_pxl),
        .mix_pxl     (mix_pxl),
        .cpsa        (cpsa),
        .pal_copy    (pal_copy),
        .pal_page_en (pal_page_en),
        .game        (game),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] merge_lanes(input logic [15:0] old_w,
                                                input logic [15:0] new_w,
                                                input logic [1:0] dsn);
        logic [15:0] r;
        r = old_w;
        if (dsn[1] == 1'b0) r[15:8] = new_w[15:8];
        if (dsn[0] == 1'b0) r[7:0] = new_w[7:0];
        return r;
    endfunction

    // word 0 sits in the top bits of the struct
    function automatic logic [15:0] cpsa_field(input cps_video_pkg::cpsa_regs_t r,
                                               input int idx);
        logic [287:0] flat;
        flat = r;
        return flat[287 - 16*idx -: 16];
    endfunction

    function automatic logic [15:0] expect_read(input logic [4:0] addr);
        logic [31:0] p;
        p = m_mult1 * m_mult2;
        if (addr == 5'h1f) return 16'hffff;
        if (addr == W_ID) return {4'h0, cfg_bytes[1][7:4], 4'h0, cfg_bytes[1][3:0]};
        if (addr == W_MULT1) return m_mult1;
        if (addr == W_MULT2) return m_mult2;
        if (addr == W_RSLT0) return p[15:0];
        if (addr == W_RSLT1) return p[31:16];
        if (addr == W_LAYER) return m_layer;
        if (addr == W_PRIO0) return m_prio[0];
        if (addr == W_PRIO1) return m_prio[1];
        if (addr == W_PRIO2) return m_prio[2];
        if (addr == W_PRIO3) return m_prio[3];
        if (addr == W_PAGE) return {10'd0, m_page};
        return 16'hffff;
    endfunction

    function automatic cps_video_pkg::pixel_t mix_ref(input cps_video_pkg::pixel_t obj,
                                                      input cps_video_pkg::pixel_t s1,
                                                      input cps_video_pkg::pixel_t s2,
                                                      input cps_video_pkg::pixel_t s3);
        cps_video_pkg::pixel_t lp [4];
        logic [3:0]            en;
        logic [1:0]            lay;
        int                    front;
        lp[0] = obj;
        lp[1] = s1;
        lp[2] = s2;
        lp[3] = s3;
        for (int i = 0; i < 4; i++) begin
            en[i] = (m_layer[7:0] & cfg_bytes[12 + i]) != 8'h00;
        end
        front = -1;
        for (int k = 3; k >= 0; k--) begin
            lay = m_layer[6 + 2*k +: 2];
            if (front < 0 && en[lay] && lp[lay].color != 4'hf) front = k;
        end
        if (front < 0) return '{color: 4'hf, group: 2'd0, pal: 5'd0};
        lay = m_layer[6 + 2*front +: 2];
        if (lay != 2'd0) return lp[lay];
        // with the sprite in front the nearest opaque scroll pixel behind may still win
        for (int k = front - 1; k >= 0; k--) begin
            lay = m_layer[6 + 2*k +: 2];
            if (lay != 2'd0 && en[lay] && lp[lay].color != 4'hf) begin
                if (m_prio[lp[lay].group][lp[lay].color]) return lp[lay];
                return lp[0];
            end
        end
        return lp[0];
    endfunction

    task automatic check16(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error %s: got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic bus_drive(input logic cs1, input logic cs2, input logic [4:0] addr,
                             input logic [1:0] dsn, input logic [15:0] data);
        ppu1_cs  = cs1;
        ppu2_cs  = cs2;
        bus.addr = addr;
        bus.dsn  = dsn;
        bus.data = data;
    endtask

    task automatic bus_release();
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        bus.dsn = 2'b11;
    endtask

    task automatic cpsb_write(input logic [4:0] addr, input logic [1:0] dsn,
                              input logic [15:0] data);
        bus_drive(1'b0, 1'b1, addr, dsn, data);
        step();
        bus_release();
        if (dsn == 2'b00) begin
            if (addr == W_MULT1) m_mult1 = data;
            if (addr == W_MULT2) m_mult2 = data;
            if (addr == W_LAYER) m_layer = data;
            if (addr == W_PRIO0) m_prio[0] = data;
            if (addr == W_PRIO1) m_prio[1] = data;
            if (addr == W_PRIO2) m_prio[2] = data;
            if (addr == W_PRIO3) m_prio[3] = data;
            if (addr == W_PAGE) m_page = data[5:0];
        end
    endtask

    task automatic read_check(input logic [4:0] addr);
        bus_drive(1'b0, 1'b1, addr, 2'b11, 16'h0000);
        step();
        bus_release();
        check16("mmr_dout", mmr_dout, expect_read(addr));
    endtask

    // first byte sent ends up as byte 20
    task automatic load_chain();
        for (int i = cps_video_pkg::CFG_BYTES - 1; i >= 0; i--) begin
            cfg_we   = 1'b1;
            cfg_data = cfg_bytes[i];
            step();
        end
        cfg_we = 1'b0;
    endtask

    task automatic rand_pixel(output cps_video_pkg::pixel_t px);
        px.color = 4'(rand_bits(4));
        if (rand_bits(2) == 32'd0) px.color = 4'hf;
        px.group = 2'(rand_bits(2));
        px.pal   = 5'(rand_bits(5));
    endtask

    always @(posedge clk) begin : mix_compare
        cps_video_pkg::pixel_t exp_pxl;
        #1;
        if (mix_queue.size() > 0) begin
            exp_pxl = mix_queue.pop_front();
            check16("mix_pxl", {5'd0, mix_pxl}, {5'd0, exp_pxl});
        end
    end

    initial begin
        logic [15:0]           data;
        logic [1:0]            dsn;
        cps_video_pkg::pixel_t px [4];

        reg_rst  = 1'b1;
        ppu1_cs  = 1'b0;
        ppu2_cs  = 1'b0;
        bus      = '{addr: 5'd0, dsn: 2'b11, data: 16'h0000};
        cfg_we   = 1'b0;
        cfg_data = 8'h00;
        obj_pxl  = '{color: 4'hf, group: 2'd0, pal: 5'd0};
        scr1_pxl = obj_pxl;
        scr2_pxl = obj_pxl;
        scr3_pxl = obj_pxl;
        for (int i = 0; i < 18; i++) a_model[i] = 16'h0000;
        for (int i = 0; i < cps_video_pkg::CFG_BYTES; i++) cfg_bytes[i] = 8'h00;

        repeat (10) @(posedge clk);
        #2;
        check16("mmr_dout", mmr_dout, 16'hffff);
        check16("pal_copy", {15'd0, pal_copy}, 16'h0000);
        check16("pal_page_en", {10'd0, pal_page_en}, 16'h003f);
        for (int i = 0; i < 18; i++) check16("cpsa", cpsa_field(cpsa, i), 16'h0000);
        reg_rst = 1'b0;
        finish_test("reset values");

        for (int i = 0; i < 18; i++) begin
            data = 16'(rand_bits(16));
            dsn  = 2'(rand_bits(2));
            bus_drive(1'b1, 1'b0, 5'(i), dsn, data);
            step();
            bus_release();
            a_model[i] = merge_lanes(a_model[i], data, dsn);
            check16("cpsa", cpsa_field(cpsa, i), a_model[i]);
        end
        for (int i = 0; i < 18; i++) check16("cpsa", cpsa_field(cpsa, i), a_model[i]);
        step();
        step();
        finish_test("cpsa writes");

        // two back to back palette base writes give one pulse after the select drops
        bus_drive(1'b1, 1'b0, cps_video_pkg::A_PAL_BASE, 2'b00, 16'h1234);
        step();
        check16("pal_copy", {15'd0, pal_copy}, 16'h0000);
        bus_drive(1'b1, 1'b0, cps_video_pkg::A_PAL_BASE, 2'b00, 16'h9abc);
        step();
        check16("pal_copy", {15'd0, pal_copy}, 16'h0000);
        bus_release();
        step();
        check16("pal_copy", {15'd0, pal_copy}, 16'h0001);
        check16("pal_base", cpsa.pal_base, 16'h9abc);
        step();
        check16("pal_copy", {15'd0, pal_copy}, 16'h0000);
        bus_drive(1'b1, 1'b0, 5'h04, 2'b00, 16'h5555);
        step();
        bus_drive(1'b1, 1'b0, 5'h06, 2'b00, 16'haaaa);
        step();
        bus_release();
        for (int i = 0; i < 3; i++) begin
            check16("pal_copy", {15'd0, pal_copy}, 16'h0000);
            step();
        end
        finish_test("palette copy");

        cfg_bytes[0]  = {2'b00, W_ID, 1'b0};
        cfg_bytes[1]  = BOARD_ID;
        cfg_bytes[2]  = {2'b00, W_MULT1, 1'b0};
        cfg_bytes[3]  = {2'b00, W_MULT2, 1'b0};
        cfg_bytes[4]  = {2'b00, W_RSLT0, 1'b0};
        cfg_bytes[5]  = {2'b00, W_RSLT1, 1'b0};
        cfg_bytes[6]  = {2'b00, W_LAYER, 1'b0};
        cfg_bytes[7]  = {2'b00, W_PRIO0, 1'b0};
        cfg_bytes[8]  = {2'b00, W_PRIO1, 1'b0};
        cfg_bytes[9]  = {2'b00, W_PRIO2, 1'b0};
        cfg_bytes[10] = {2'b00, W_PRIO3, 1'b0};
        cfg_bytes[11] = {2'b00, W_PAGE, 1'b0};
        for (int i = 12; i < 16; i++) cfg_bytes[i] = 8'(rand_bits(8));
        cfg_bytes[16] = 8'h2b;
        cfg_bytes[17] = 8'h34;
        cfg_bytes[18] = 8'h12;
        cfg_bytes[19] = 8'hff;
        cfg_bytes[20] = 8'h0f;
        load_chain();
        check16("game", {10'd0, game}, {10'd0, cfg_bytes[16][5:0]});
        check16("bank_offset", bank_offset, {cfg_bytes[18], cfg_bytes[17]});
        check16("bank_mask", bank_mask, {cfg_bytes[20], cfg_bytes[19]});
        read_check(W_ID);
        read_check(5'h00);
        read_check(5'h1e);
        read_check(5'h1f);
        read_check(W_LAYER);
        read_check(W_PRIO2);
        read_check(W_PAGE);
        finish_test("configuration chain");

        for (int i = 0; i < 8; i++) begin
            cpsb_write(W_MULT1, 2'b00, 16'(rand_bits(16)));
            cpsb_write(W_MULT2, 2'b00, 16'(rand_bits(16)));
            step();
            read_check(W_RSLT0);
            read_check(W_RSLT1);
            read_check(W_MULT1);
            read_check(W_MULT2);
        end
        cpsb_write(W_LAYER, 2'b00, 16'(rand_bits(16)));
        cpsb_write(W_PRIO0, 2'b00, 16'(rand_bits(16)));
        cpsb_write(W_PRIO1, 2'b00, 16'(rand_bits(16)));
        cpsb_write(W_PRIO2, 2'b00, 16'(rand_bits(16)));
        cpsb_write(W_PRIO3, 2'b00, 16'(rand_bits(16)));
        cpsb_write(W_PAGE, 2'b00, 16'(rand_bits(16)));
        check16("pal_page_en", {10'd0, pal_page_en}, {10'd0, m_page});
        // byte writes leave CPS-B registers untouched
        cpsb_write(W_LAYER, 2'b01, 16'(rand_bits(16)));
        cpsb_write(W_PRIO1, 2'b10, 16'(rand_bits(16)));
        cpsb_write(W_MULT1, 2'b01, 16'(rand_bits(16)));
        step();
        read_check(W_LAYER);
        read_check(W_PRIO0);
        read_check(W_PRIO1);
        read_check(W_PRIO2);
        read_check(W_PRIO3);
        read_check(W_PAGE);
        read_check(W_MULT1);
        read_check(W_RSLT0);
        finish_test("cpsb registers");

        for (int r = 0; r < MIX_ROUNDS; r++) begin
            for (int i = 12; i < 16; i++) cfg_bytes[i] = 8'(rand_bits(8));
            load_chain();
            cpsb_write(W_LAYER, 2'b00, 16'(rand_bits(16)));
            cpsb_write(W_PRIO0, 2'b00, 16'(rand_bits(16)));
            cpsb_write(W_PRIO1, 2'b00, 16'(rand_bits(16)));
            cpsb_write(W_PRIO2, 2'b00, 16'(rand_bits(16)));
            cpsb_write(W_PRIO3, 2'b00, 16'(rand_bits(16)));
            for (int p = 0; p < MIX_PIXELS; p++) begin
                for (int i = 0; i < 4; i++) rand_pixel(px[i]);
                obj_pxl  = px[0];
                scr1_pxl = px[1];
                scr2_pxl = px[2];
                scr3_pxl = px[3];
                mix_queue.push_back(mix_ref(px[0], px[1], px[2], px[3]));
                step();
            end
        end
        step();
        if (mix_queue.size() != 0) begin
            $display("mixer results were still pending at the end of the test");
            errors++;
            test_errors++;
        end
        finish_test("layer mixer");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: cps_video_ctrl.f
verilog/cps_video_pkg.sv
verilog/cpsa_regs.sv
verilog/cpsb_cfg.sv
verilog/cpsb_regs.sv
verilog/layer_mixer.sv
verilog/cps_video_ctrl.sv
tb/cps_video_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the video register testbench

VERILATOR ?= verilator
TOP       ?= cps_video_ctrl_tb
FILELIST  ?= cps_video_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation reported failure" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
